//--- m92_glue_pkg.sv
// M92 CPU glue shared types: bus widths, address map, I/O ports and state encodings
package m92_glue_pkg;

    // ========================================
    // Widths with a meaning
    // ========================================
    typedef logic [19:0] cpu_addr_t;    // CPU byte address
    typedef logic [15:0] cpu_word_t;
    typedef logic [1:0]  byte_sel_t;    // Bit 1 is the upper lane
    typedef logic [24:0] sdr_addr_t;
    typedef logic [7:0]  io_addr_t;
    typedef logic [7:0]  io_byte_t;
    typedef logic [3:0]  bank_t;
    typedef logic [9:0]  player_in_t;

    typedef enum logic [2:0] {
        region_rom,
        region_banked,
        region_ram,
        region_vid_ctrl,
        region_none
    } mem_region_t;

    typedef enum logic [0:0] {
        mem_idle,
        mem_wait
    } mem_state_t;

    typedef struct packed {
        logic kick_harness;     // Kick buttons wired through the P4 port
        logic large_tileset;
    } board_cfg_t;

    typedef struct packed {
        logic      rd;          // Single-cycle strobes
        logic      wr;
        byte_sel_t byte_sel;
        cpu_addr_t addr;
        cpu_word_t wdata;
    } cpu_bus_t;

    // ========================================
    // Address map
    // ========================================
    localparam cpu_addr_t ROM_END        = 20'h9FFFF;
    localparam cpu_addr_t BANK_WIN_START = 20'hA0000;
    localparam cpu_addr_t BANK_WIN_END   = 20'hBFFFF;
    localparam sdr_addr_t BANK_BASE      = 25'h0100000;
    localparam cpu_addr_t RAM_START      = 20'hE0000;
    localparam cpu_addr_t RAM_END        = 20'hEFFFF;
    localparam sdr_addr_t RAM_BASE       = 25'h0400000;
    localparam cpu_addr_t VID_CTRL_ADDR  = 20'hF9000;

    // I/O ports, word aligned
    localparam io_addr_t IO_SW_P1P2   = 8'h00;
    localparam io_addr_t IO_FLAGS     = 8'h02;
    localparam io_addr_t IO_DIP       = 8'h04;
    localparam io_addr_t IO_SW_P3P4   = 8'h06;
    localparam io_addr_t IO_SND_LATCH = 8'h08;
    localparam io_addr_t IO_BANK      = 8'h20;

endpackage

//--- m92_cpu_clock.sv
// CPU clock enable generator with memory stall and vertical-pulse synchronized pause
`timescale 1ns/1ps

module m92_cpu_clock #(
    parameter int CE_DIV = 4
) (
    input  logic clk_sys,
    input  logic reset_n,
    input  logic mem_busy,
    input  logic sdram_pending,
    input  logic bus_active,
    input  logic pause_rq,
    input  logic vpulse,
    output logic ce_cpu,
    output logic ce_4x,
    output logic cpu_paused
);

    localparam int CNT_W = (CE_DIV > 1) ? $clog2(CE_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CE_DIV - 1);

    logic [CNT_W-1:0] ce_cnt;
    logic             stall;
    logic             paused_nxt;

    assign stall = mem_busy | sdram_pending;   // Hold the CPU while SDRAM is fetched

    // Enter pause only on an idle vpulse cycle, leave once request and vpulse drop
    always_comb begin
        paused_nxt = cpu_paused;
        if (!cpu_paused) begin
            if (pause_rq && vpulse && !mem_busy && !bus_active) begin
                paused_nxt = 1'b1;
            end
        end else if (!pause_rq && !vpulse) begin
            paused_nxt = 1'b0;
        end
    end

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            ce_cpu     <= 1'b0;
            ce_4x      <= 1'b0;
            ce_cnt     <= '0;
            cpu_paused <= 1'b0;
        end else begin
            ce_cpu     <= 1'b0;
            ce_4x      <= 1'b0;
            cpu_paused <= paused_nxt;
            if (!stall && !paused_nxt) begin
                ce_4x  <= 1'b1;
                ce_cpu <= (ce_cnt == CNT_LAST);
                ce_cnt <= (ce_cnt == CNT_LAST) ? '0 : ce_cnt + 1'b1;
            end
        end
    end

    a_ce_cpu_in_4x: assert property (@(posedge clk_sys) disable iff (!reset_n)
        ce_cpu |-> ce_4x);

    // Pause entry is seen one cycle late, so this also covers the entry edge
    a_no_ce_paused: assert property (@(posedge clk_sys) disable iff (!reset_n)
        cpu_paused |-> !(ce_4x || ce_cpu));

endmodule

//--- m92_addr_map.sv
// CPU address decoder: region select, SDRAM translation and write protection
`timescale 1ns/1ps

module m92_addr_map (
    input  m92_glue_pkg::cpu_addr_t   addr,
    input  m92_glue_pkg::bank_t       bank,
    output m92_glue_pkg::mem_region_t region,
    output m92_glue_pkg::sdr_addr_t   sdr_addr,
    output logic                      writable
);

    import m92_glue_pkg::*;

    cpu_addr_t word_addr;
    sdr_addr_t bank_offset;

    assign word_addr   = {addr[19:1], 1'b0};
    assign bank_offset = sdr_addr_t'({bank, 17'd0});   // 128 KB per bank

    // ========================================
    // Region decode
    // ========================================
    always_comb begin
        if (addr <= ROM_END) begin
            region = region_rom;
        end else if (addr >= BANK_WIN_START && addr <= BANK_WIN_END) begin
            region = region_banked;
        end else if (addr >= RAM_START && addr <= RAM_END) begin
            region = region_ram;
        end else if (word_addr == VID_CTRL_ADDR) begin
            region = region_vid_ctrl;
        end else begin
            region = region_none;
        end
    end

    // SDRAM translation
    always_comb begin
        case (region)
            region_rom: begin
                sdr_addr = sdr_addr_t'(addr);
            end
            region_banked: begin
                sdr_addr = BANK_BASE + bank_offset + sdr_addr_t'(addr[16:0]);
            end
            region_ram: begin
                sdr_addr = RAM_BASE + sdr_addr_t'(addr[15:0]);
            end
            default: begin
                sdr_addr = '0;
            end
        endcase
    end

    assign writable = (region == region_ram);  // ROM and bank window are read-only

endmodule

//--- m92_mem_port.sv
// CPU memory port: SDRAM requests, video control register and read data lane shuffle
`timescale 1ns/1ps

module m92_mem_port (
    input  logic                      clk_sys,
    input  logic                      reset_n,
    input  m92_glue_pkg::cpu_bus_t    bus,
    input  m92_glue_pkg::mem_region_t region,
    input  m92_glue_pkg::sdr_addr_t   sdr_addr,
    input  logic                      writable,
    input  m92_glue_pkg::cpu_word_t   sdr_cpu_dout,
    input  logic                      sdr_cpu_rdy,
    output m92_glue_pkg::sdr_addr_t   sdr_cpu_addr,
    output m92_glue_pkg::cpu_word_t   sdr_cpu_din,
    output m92_glue_pkg::byte_sel_t   sdr_cpu_wr_sel,
    output logic                      sdr_cpu_req,
    output logic                      mem_busy,
    output logic                      sdram_pending,
    output m92_glue_pkg::cpu_word_t   cpu_mem_in,
    output m92_glue_pkg::cpu_word_t   vid_ctrl
);

    import m92_glue_pkg::*;

    mem_state_t  state;
    mem_region_t rd_region;     // Region of the last read
    logic        rd_odd;
    cpu_word_t   sdram_data;
    cpu_word_t   word_out;
    byte_sel_t   word_sel;
    cpu_word_t   rd_word;

    // Odd byte writes go out on the upper lane
    assign word_out = bus.addr[0] ? {bus.wdata[7:0], 8'h00} : bus.wdata;
    assign word_sel = bus.addr[0] ? {bus.byte_sel[0], 1'b0} : bus.byte_sel;

    assign sdram_pending = (bus.rd | bus.wr) &
                           (region == region_rom || region == region_banked ||
                            region == region_ram);
    assign mem_busy = (state == mem_wait);

    // ========================================
    // Request FSM and video control
    // ========================================
    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            state       <= mem_idle;
            sdr_cpu_req <= 1'b0;
            vid_ctrl    <= '0;
            rd_region   <= region_none;
        end else begin
            sdr_cpu_req <= 1'b0;
            if (state == mem_idle && sdram_pending) begin
                sdr_cpu_req <= 1'b1;
                state       <= mem_wait;
            end else if (state == mem_wait && sdr_cpu_rdy) begin
                state <= mem_idle;
            end
            if (bus.wr && region == region_vid_ctrl) vid_ctrl <= word_out;
            if (bus.rd) rd_region <= region;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (state == mem_idle && sdram_pending) begin
            sdr_cpu_addr   <= sdr_addr;
            sdr_cpu_din    <= word_out;
            sdr_cpu_wr_sel <= (bus.wr && writable) ? word_sel : 2'b00;  // Protected writes
        end
        if (state == mem_wait && sdr_cpu_rdy) sdram_data <= sdr_cpu_dout;
        if (bus.rd) rd_odd <= bus.addr[0];
    end

    // Read data mux
    assign rd_word = (rd_region == region_vid_ctrl) ? vid_ctrl : sdram_data;

    always_comb begin
        if (rd_region == region_none) begin
            cpu_mem_in = 16'hFFFF;
        end else if (rd_odd) begin
            cpu_mem_in = {8'h00, rd_word[15:8]};   // Upper byte moves to low lane
        end else begin
            cpu_mem_in = rd_word;
        end
    end

    a_rdy_in_wait: assert property (@(posedge clk_sys) disable iff (!reset_n)
        sdr_cpu_rdy |-> state == mem_wait);

    // The clock enables are stalled, so no new access may land mid-fetch
    a_no_req_busy: assert property (@(posedge clk_sys) disable iff (!reset_n)
        sdram_pending |-> state == mem_idle);

endmodule

//--- m92_io_regs.sv
// CPU I/O ports: switch, flag and DIP read map with harness wiring, bank select register
`timescale 1ns/1ps

module m92_io_regs (
    input  logic                     clk_sys,
    input  logic                     reset_n,
    input  m92_glue_pkg::board_cfg_t board_cfg,
    input  logic                     io_wr,
    input  m92_glue_pkg::io_addr_t   io_addr,
    input  m92_glue_pkg::io_byte_t   io_out,
    input  logic [3:0]               coin,
    input  logic [3:0]               start_buttons,
    input  m92_glue_pkg::player_in_t p1_input,
    input  m92_glue_pkg::player_in_t p2_input,
    input  m92_glue_pkg::player_in_t p3_input,
    input  m92_glue_pkg::player_in_t p4_input,
    input  logic [23:0]              dip_sw,
    output m92_glue_pkg::io_byte_t   io_in,
    output m92_glue_pkg::bank_t      bank
);

    import m92_glue_pkg::*;

    io_byte_t  sw_p1;
    io_byte_t  sw_p2;
    io_byte_t  sw_p3;
    io_byte_t  sw_p4;
    logic      kick;
    logic [15:0] flags;
    logic [15:0] io_word;
    io_addr_t  word_addr;

    // Common switch layout, bits 5 and 4 vary per port
    function automatic io_byte_t sw_byte(input player_in_t p, input logic b5, input logic b4);
        sw_byte = {p[4], p[5], b5, b4, p[3:0]};
    endfunction

    assign kick = board_cfg.kick_harness;

    // ========================================
    // Switch bytes
    // ========================================
    assign sw_p1 = sw_byte(p1_input, kick & p1_input[6], 1'b0);
    assign sw_p2 = sw_byte(p2_input, kick & p2_input[6], 1'b0);

    always_comb begin
        if (kick) begin
            sw_p3 = 8'h00;
            // Kick harness reuses P4 for the extra P1/P2 buttons
            sw_p4 = {p2_input[9], p2_input[8], p2_input[7], 1'b0,
                     p1_input[9], p1_input[8], p1_input[7], 1'b0};
        end else begin
            sw_p3 = sw_byte(p3_input, coin[2], start_buttons[2]);
            sw_p4 = sw_byte(p4_input, coin[3], start_buttons[3]);
        end
    end

    // DMA reads idle, then test, R and spare bits high
    assign flags = {~dip_sw[23:16], 1'b0, 3'b111, ~coin[1:0], ~start_buttons[1:0]};

    // ========================================
    // Read map
    // ========================================
    assign word_addr = {io_addr[7:1], 1'b0};

    always_comb begin
        case (word_addr)
            IO_SW_P1P2:   io_word = {~sw_p2, ~sw_p1};
            IO_FLAGS:     io_word = flags;
            IO_DIP:       io_word = ~dip_sw[15:0];
            IO_SW_P3P4:   io_word = {~sw_p4, ~sw_p3};
            IO_SND_LATCH: io_word = 16'hFFFF;   // No sound CPU here
            default:      io_word = 16'hFFFF;
        endcase
    end

    assign io_in = io_addr[0] ? io_word[15:8] : io_word[7:0];

    // Bank select for the ROM window
    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            bank <= '0;
        end else if (io_wr && io_addr == IO_BANK) begin
            bank <= io_out[3:0];
        end
    end

endmodule

//--- m92_cpu_glue.sv
// M92 main CPU glue top level: clock enables, address map, SDRAM port and I/O ports
`timescale 1ns/1ps

module m92_cpu_glue #(
    parameter int CE_DIV = 4
) (
    input  logic                     clk_sys,
    input  logic                     reset_n,
    input  m92_glue_pkg::board_cfg_t board_cfg,
    input  m92_glue_pkg::cpu_bus_t   cpu_bus,
    input  logic                     io_rd,
    input  logic                     io_wr,
    input  m92_glue_pkg::io_addr_t   io_addr,
    input  m92_glue_pkg::io_byte_t   io_out,
    input  logic                     pause_rq,
    input  logic                     vpulse,
    input  m92_glue_pkg::cpu_word_t  sdr_cpu_dout,
    input  logic                     sdr_cpu_rdy,
    input  logic [3:0]               coin,
    input  logic [3:0]               start_buttons,
    input  m92_glue_pkg::player_in_t p1_input,
    input  m92_glue_pkg::player_in_t p2_input,
    input  m92_glue_pkg::player_in_t p3_input,
    input  m92_glue_pkg::player_in_t p4_input,
    input  logic [23:0]              dip_sw,
    output logic                     ce_cpu,
    output logic                     ce_4x,
    output logic                     cpu_paused,
    output m92_glue_pkg::cpu_word_t  cpu_mem_in,
    output m92_glue_pkg::io_byte_t   io_in,
    output m92_glue_pkg::sdr_addr_t  sdr_cpu_addr,
    output m92_glue_pkg::cpu_word_t  sdr_cpu_din,
    output logic                     sdr_cpu_req,
    output m92_glue_pkg::byte_sel_t  sdr_cpu_wr_sel,
    output m92_glue_pkg::cpu_word_t  vid_ctrl
);

    import m92_glue_pkg::*;

    mem_region_t region;
    sdr_addr_t   sdr_addr;
    bank_t       bank;
    logic        writable;
    logic        mem_busy;
    logic        sdram_pending;
    logic        bus_active;

    assign bus_active = cpu_bus.rd | cpu_bus.wr | io_rd | io_wr;  // Any strobe blocks pause

    m92_cpu_clock #(.CE_DIV(CE_DIV)) u_cpu_clock (
        .clk_sys       (clk_sys),
        .reset_n       (reset_n),
        .mem_busy      (mem_busy),
        .sdram_pending (sdram_pending),
        .bus_active    (bus_active),
        .pause_rq      (pause_rq),
        .vpulse        (vpulse),
        .ce_cpu        (ce_cpu),
        .ce_4x         (ce_4x),
        .cpu_paused    (cpu_paused)
    );

    m92_addr_map u_addr_map (
        .addr     (cpu_bus.addr),
        .bank     (bank),
        .region   (region),
        .sdr_addr (sdr_addr),
        .writable (writable)
    );

    m92_mem_port u_mem_port (
        .clk_sys        (clk_sys),
        .reset_n        (reset_n),
        .bus            (cpu_bus),
        .region         (region),
        .sdr_addr       (sdr_addr),
        .writable       (writable),
        .sdr_cpu_dout   (sdr_cpu_dout),
        .sdr_cpu_rdy    (sdr_cpu_rdy),
        .sdr_cpu_addr   (sdr_cpu_addr),
        .sdr_cpu_din    (sdr_cpu_din),
        .sdr_cpu_wr_sel (sdr_cpu_wr_sel),
        .sdr_cpu_req    (sdr_cpu_req),
        .mem_busy       (mem_busy),
        .sdram_pending  (sdram_pending),
        .cpu_mem_in     (cpu_mem_in),
        .vid_ctrl       (vid_ctrl)
    );

    m92_io_regs u_io_regs (
        .clk_sys       (clk_sys),
        .reset_n       (reset_n),
        .board_cfg     (board_cfg),
        .io_wr         (io_wr),
        .io_addr       (io_addr),
        .io_out        (io_out),
        .coin          (coin),
        .start_buttons (start_buttons),
        .p1_input      (p1_input),
        .p2_input      (p2_input),
        .p3_input      (p3_input),
        .p4_input      (p4_input),
        .dip_sw        (dip_sw),
        .io_in         (io_in),
        .bank          (bank)
    );

endmodule

//--- tb_clock.sv
// Testbench clock and reset source for the M92 CPU glue
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_sys,
    output logic reset_n
);

    initial begin
        clk_sys = 1'b0;
        forever #(PERIOD_NS / 2) clk_sys = ~clk_sys;
    end

    // Release just after an edge, clear of the DUT flops
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_sys);
        #1 reset_n = 1'b1;
    end

endmodule

//--- tb_m92_glue.sv
// Testbench for the M92 CPU glue: random CPU, I/O and pause stimulus against a reference model
`timescale 1ns/1ps

module tb_m92_glue;

    import m92_glue_pkg::*;

    localparam int CE_DIV     = 4;
    localparam int N_ACCESS   = 400;
    localparam int N_IO_ROUND = 24;
    localparam int MAX_CYCLES = N_ACCESS * 40 + 4000;   // Worst fetch per access plus I/O and pause

    logic        clk_sys;
    logic        reset_n;
    board_cfg_t  board_cfg;
    cpu_bus_t    cpu_bus;
    logic        io_rd;
    logic        io_wr;
    io_addr_t    io_addr;
    io_byte_t    io_out;
    logic        pause_rq;
    logic        vpulse;
    cpu_word_t   sdr_cpu_dout;
    logic        sdr_cpu_rdy;
    logic [3:0]  coin;
    logic [3:0]  start_buttons;
    player_in_t  p1_input;
    player_in_t  p2_input;
    player_in_t  p3_input;
    player_in_t  p4_input;
    logic [23:0] dip_sw;
    logic        ce_cpu;
    logic        ce_4x;
    logic        cpu_paused;
    cpu_word_t   cpu_mem_in;
    io_byte_t    io_in;
    sdr_addr_t   sdr_cpu_addr;
    cpu_word_t   sdr_cpu_din;
    logic        sdr_cpu_req;
    byte_sel_t   sdr_cpu_wr_sel;
    cpu_word_t   vid_ctrl;

    int          seed = 32'h95ec_2010;

    // ========================================
    // Reference model state
    // ========================================
    cpu_word_t   sdram_mem [logic [23:0]];   // Sparse, keyed by word address
    bank_t       bank_model;
    cpu_word_t   vid_model;
    logic        paused_model;
    logic        saw_pause;
    logic        fetch;
    logic        after_rdy;
    int          ce4_count;
    int          req_count;
    int          cycles;
    logic        exp_req;           // Next SDRAM request as predicted
    logic        exp_wr;
    sdr_addr_t   exp_addr;
    byte_sel_t   exp_sel;
    cpu_word_t   exp_din;
    int          exp_latency;

    tb_clock #(.PERIOD_NS(40), .RESET_CYCLES(5)) u_clock (
        .clk_sys (clk_sys),
        .reset_n (reset_n)
    );

    m92_cpu_glue #(.CE_DIV(CE_DIV)) u_dut (
        .clk_sys        (clk_sys),
        .reset_n        (reset_n),
        .board_cfg      (board_cfg),
        .cpu_bus        (cpu_bus),
        .io_rd          (io_rd),
        .io_wr          (io_wr),
        .io_addr        (io_addr),
        .io_out         (io_out),
        .pause_rq       (pause_rq),
        .vpulse         (vpulse),
        .sdr_cpu_dout   (sdr_cpu_dout),
        .sdr_cpu_rdy    (sdr_cpu_rdy),
        .coin           (coin),
        .start_buttons  (start_buttons),
        .p1_input       (p1_input),
        .p2_input       (p2_input),
        .p3_input       (p3_input),
        .p4_input       (p4_input),
        .dip_sw         (dip_sw),
        .ce_cpu         (ce_cpu),
        .ce_4x          (ce_4x),
        .cpu_paused     (cpu_paused),
        .cpu_mem_in     (cpu_mem_in),
        .io_in          (io_in),
        .sdr_cpu_addr   (sdr_cpu_addr),
        .sdr_cpu_din    (sdr_cpu_din),
        .sdr_cpu_req    (sdr_cpu_req),
        .sdr_cpu_wr_sel (sdr_cpu_wr_sel),
        .vid_ctrl       (vid_ctrl)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s: got %0h, expected %0h", $time, name, actual, expected);
            $display("Something failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // Untouched SDRAM words hold a pattern of their own address
    function automatic cpu_word_t fill_word(input logic [23:0] idx);
        fill_word = idx[15:0] ^ {idx[23:16], idx[23:16]} ^ 16'h5AC3;
    endfunction

    function automatic cpu_word_t mem_word(input sdr_addr_t a);
        if (sdram_mem.exists(a[24:1])) begin
            mem_word = sdram_mem[a[24:1]];
        end else begin
            mem_word = fill_word(a[24:1]);
        end
    endfunction

    function automatic io_byte_t player_byte(input player_in_t p, input logic b5, input logic b4);
        io_byte_t b;
        b      = '0;
        b[7]   = p[4];
        b[6]   = p[5];
        b[5]   = b5;
        b[4]   = b4;
        b[3:0] = p[3:0];
        player_byte = b;
    endfunction

    function automatic io_byte_t expected_io(input io_addr_t a);
        io_byte_t  sw1;
        io_byte_t  sw2;
        io_byte_t  sw3;
        io_byte_t  sw4;
        cpu_word_t word;
        sw1 = player_byte(p1_input, board_cfg.kick_harness & p1_input[6], 1'b0);
        sw2 = player_byte(p2_input, board_cfg.kick_harness & p2_input[6], 1'b0);
        if (board_cfg.kick_harness) begin
            sw3 = 8'h00;
            sw4 = {p2_input[9:7], 1'b0, p1_input[9:7], 1'b0};
        end else begin
            sw3 = player_byte(p3_input, coin[2], start_buttons[2]);
            sw4 = player_byte(p4_input, coin[3], start_buttons[3]);
        end
        case (a[7:1])
            7'd0:    word = {~sw2, ~sw1};
            7'd1: begin
                word[15:8] = ~dip_sw[23:16];
                word[7]    = 1'b0;      // DMA idle
                word[6:4]  = 3'b111;
                word[3:2]  = ~coin[1:0];
                word[1:0]  = ~start_buttons[1:0];
            end
            7'd2:    word = ~dip_sw[15:0];
            7'd3:    word = {~sw4, ~sw3};
            default: word = 16'hFFFF;
        endcase
        expected_io = a[0] ? word[15:8] : word[7:0];
    endfunction

    task automatic wait_ce();
        do begin
            @(negedge clk_sys);
        end while (!ce_cpu);
    endtask

    // One random CPU access, started from a ce_cpu cycle and ended at the next one
    task automatic do_access();
        int        kind;
        int        req_before;
        logic      is_wr;
        logic      sdram;
        logic      writable;
        cpu_addr_t addr;
        cpu_word_t wdata;
        cpu_word_t word;
        byte_sel_t sel;
        sdr_addr_t eaddr;
        kind     = $unsigned($random(seed)) % 6;
        is_wr    = $random(seed);
        wdata    = $random(seed);
        sel      = $random(seed);
        addr     = $random(seed);
        sdram    = 1'b1;
        writable = 1'b0;
        eaddr    = '0;
        case (kind)
            0: begin
                addr  = addr % 20'hA0000;
                eaddr = sdr_addr_t'(addr);
            end
            1: begin
                addr  = BANK_WIN_START + addr[16:0];
                eaddr = BANK_BASE + sdr_addr_t'(bank_model) * 25'h20000 + addr[16:0];
            end
            2: begin
                addr     = RAM_START + (addr & 20'h0F03F);   // Dense enough to hit old writes
                eaddr    = RAM_BASE + addr[15:0];
                writable = 1'b1;
            end
            3: begin
                addr  = VID_CTRL_ADDR + addr[0];
                sdram = 1'b0;
            end
            4: begin
                addr  = 20'hC0000 + addr[16:0];   // Hole between bank window and RAM
                sdram = 1'b0;
            end
            default: begin
                @(posedge clk_sys);
                #1;
                io_addr    = IO_BANK;
                io_out     = $random(seed);
                io_wr      = 1'b1;
                bank_model = io_out[3:0];
                @(posedge clk_sys);
                #1;
                io_wr = 1'b0;
                wait_ce();
                return;
            end
        endcase
        @(posedge clk_sys);
        #1;
        exp_req          = sdram;
        exp_wr           = is_wr;
        exp_addr         = eaddr;
        exp_sel          = (is_wr && writable) ? (addr[0] ? {sel[0], 1'b0} : sel) : 2'b00;
        exp_din          = addr[0] ? {wdata[7:0], 8'h00} : wdata;
        exp_latency      = 1 + $unsigned($random(seed)) % 8;
        req_before       = req_count;
        cpu_bus.rd       = !is_wr;
        cpu_bus.wr       = is_wr;
        cpu_bus.addr     = addr;
        cpu_bus.wdata    = wdata;
        cpu_bus.byte_sel = sel;
        @(posedge clk_sys);
        #1;
        cpu_bus.rd = 1'b0;
        cpu_bus.wr = 1'b0;
        if (is_wr && kind == 3) vid_model = exp_din;
        wait_ce();
        exp_req = 1'b0;
        check_value("sdr_cpu_req count", req_count, req_before + sdram);
        check_value("vid_ctrl", vid_ctrl, vid_model);
        if (!is_wr) begin
            if (kind == 4) begin
                word = 16'hFFFF;
            end else begin
                word = (kind == 3) ? vid_model : mem_word(eaddr);
                if (addr[0]) word = {8'h00, word[15:8]};
            end
            check_value("cpu_mem_in", cpu_mem_in, word);
        end
    endtask

    task automatic run_io_round(input int round);
        int a;
        board_cfg.kick_harness  = round[0];
        board_cfg.large_tileset = $random(seed);
        coin          = $random(seed);
        start_buttons = $random(seed);
        p1_input      = $random(seed);
        p2_input      = $random(seed);
        p3_input      = $random(seed);
        p4_input      = $random(seed);
        dip_sw        = $random(seed);
        for (a = 0; a < 13; a++) begin
            io_addr = (a < 12) ? io_addr_t'(a) : io_addr_t'($random(seed));
            io_rd   = 1'b1;
            @(negedge clk_sys);
            check_value($sformatf("io_in[%02h]", io_addr), io_in, expected_io(io_addr));
            @(posedge clk_sys);
            #1;
        end
        io_rd = 1'b0;
    endtask

    task automatic run_pause();
        int i;
        pause_rq = 1'b1;
        for (i = 0; i < 80; i++) begin
            vpulse = ($unsigned($random(seed)) % 4) == 0;
            io_rd  = ($unsigned($random(seed)) % 3) == 0;   // Strobes hold off pause entry
            @(posedge clk_sys);
            #1;
        end
        pause_rq = 1'b0;
        io_rd    = 1'b0;
        for (i = 0; i < 20; i++) begin
            vpulse = ($unsigned($random(seed)) % 4) == 0;
            @(posedge clk_sys);
            #1;
        end
        vpulse = 1'b0;
        repeat (3) @(posedge clk_sys);
        #1;
        check_value("pause entered", saw_pause, 1'b1);
        check_value("cpu_paused at end", cpu_paused, 1'b0);
    endtask

    // ========================================
    // SDRAM model
    // ========================================
    initial begin
        cpu_word_t   word;
        logic [23:0] idx;
        int          lat;
        forever begin
            @(negedge clk_sys);
            if (reset_n && sdr_cpu_req) begin
                req_count++;
                check_value("sdr_cpu_req", 1'b1, exp_req);
                check_value("sdr_cpu_addr", sdr_cpu_addr, exp_addr);
                check_value("sdr_cpu_wr_sel", sdr_cpu_wr_sel, exp_sel);
                if (exp_wr) check_value("sdr_cpu_din", sdr_cpu_din, exp_din);
                idx  = sdr_cpu_addr[24:1];
                word = mem_word(sdr_cpu_addr);
                if (sdr_cpu_wr_sel[0]) word[7:0] = sdr_cpu_din[7:0];
                if (sdr_cpu_wr_sel[1]) word[15:8] = sdr_cpu_din[15:8];
                if (sdr_cpu_wr_sel != 2'b00) sdram_mem[idx] = word;
                lat = exp_latency;
                repeat (lat) @(posedge clk_sys);
                #1;
                sdr_cpu_rdy  = 1'b1;
                sdr_cpu_dout = word;
                @(posedge clk_sys);
                #1;
                sdr_cpu_rdy = 1'b0;
            end
        end
    end

    // Stall, enable ratio and pause monitor
    always @(negedge clk_sys) begin
        if (reset_n) begin
            check_value("cpu_paused", cpu_paused, paused_model);
            if (cpu_paused) begin
                saw_pause = 1'b1;
                check_value("ce_4x while paused", ce_4x, 1'b0);
                check_value("ce_cpu while paused", ce_cpu, 1'b0);
            end
            if (sdr_cpu_req) fetch = 1'b1;
            if (fetch || after_rdy) begin
                check_value("ce_4x during fetch", ce_4x, 1'b0);
                check_value("ce_cpu during fetch", ce_cpu, 1'b0);
            end
            after_rdy = 1'b0;
            if (!paused_model) begin
                if (pause_rq && vpulse && !fetch &&
                    !(cpu_bus.rd || cpu_bus.wr || io_rd || io_wr)) begin
                    paused_model = 1'b1;
                end
            end else if (!pause_rq && !vpulse) begin
                paused_model = 1'b0;
            end
            if (sdr_cpu_rdy) begin
                fetch     = 1'b0;
                after_rdy = 1'b1;   // One more stalled cycle follows rdy
            end
            if (ce_4x) ce4_count++;
            if (ce_cpu) begin
                check_value("ce_4x pulses per ce_cpu", ce4_count, CE_DIV);
                ce4_count = 0;
            end
        end
    end

    always @(posedge clk_sys) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        int i;
        board_cfg     = '0;
        cpu_bus       = '0;
        io_rd         = 1'b0;
        io_wr         = 1'b0;
        io_addr       = '0;
        io_out        = '0;
        pause_rq      = 1'b0;
        vpulse        = 1'b0;
        sdr_cpu_dout  = '0;
        sdr_cpu_rdy   = 1'b0;
        coin          = '0;
        start_buttons = '0;
        p1_input      = '0;
        p2_input      = '0;
        p3_input      = '0;
        p4_input      = '0;
        dip_sw        = '0;
        bank_model    = '0;
        vid_model     = '0;
        paused_model  = 1'b0;
        saw_pause     = 1'b0;
        fetch         = 1'b0;
        after_rdy     = 1'b0;
        ce4_count     = 0;
        req_count     = 0;
        cycles        = 0;
        exp_req       = 1'b0;
        exp_wr        = 1'b0;
        exp_addr      = '0;
        exp_sel       = '0;
        exp_din       = '0;
        exp_latency   = 1;
        wait (reset_n);
        wait_ce();
        for (i = 0; i < N_ACCESS; i++) do_access();
        @(posedge clk_sys);
        #1;
        for (i = 0; i < N_IO_ROUND; i++) run_io_round(i);
        run_pause();
        $display("Everything OK");
        $finish;
    end

endmodule

//--- files.f
m92_glue_pkg.sv
m92_cpu_clock.sv
m92_addr_map.sv
m92_mem_port.sv
m92_io_regs.sv
m92_cpu_glue.sv
tb_clock.sv
tb_m92_glue.sv
